// ==== design/pcie_tlp_pkg.sv ====
// TLP format/type codes, header field widths, TLP kind enum and decoded header structs
`default_nettype none

package pcie_tlp_pkg;

    //////////////////////////////////////////////////
    // format and type codes, {fmt[2:0], type[4:0]}
    //////////////////////////////////////////////////
    localparam logic [7:0] FMT_TYPE_MRD32   = 8'h00;
    localparam logic [7:0] FMT_TYPE_MRD64   = 8'h20;
    localparam logic [7:0] FMT_TYPE_MRDLK32 = 8'h01;
    localparam logic [7:0] FMT_TYPE_MRDLK64 = 8'h21;
    localparam logic [7:0] FMT_TYPE_MWR32   = 8'h40;
    localparam logic [7:0] FMT_TYPE_MWR64   = 8'h60;
    localparam logic [7:0] FMT_TYPE_CPLD    = 8'h4A;
    localparam logic [7:0] FMT_TYPE_CPLDLK  = 8'h4B;

    // header field widths
    localparam int LEN_W   = 10;
    localparam int ADDR_W  = 64;
    localparam int TAG_W   = 8;
    localparam int ID_W    = 16;
    localparam int BCNT_W  = 12;
    localparam int LADDR_W = 7;

    typedef enum logic [1:0] {
        TLP_NONE,
        TLP_MRD,
        TLP_MWR,
        TLP_CPLD
    } tlp_kind_e;

    //////////////////////////////////////////////////
    // decoded headers
    //////////////////////////////////////////////////
    typedef struct packed {
        logic [2:0]        tc;
        logic [2:0]        attr;
        logic [LEN_W-1:0]  len;
        logic [ID_W-1:0]   req_id;
        logic [TAG_W-1:0]  tag;
        logic [ADDR_W-1:0] addr;
    } mrd_hdr_t;

    typedef struct packed {
        logic [LEN_W-1:0]  len;
        logic [7:0]        dwbe;
        logic [ADDR_W-1:0] addr;
        logic [1:0]        bar_hit;
    } mwr_hdr_t;

    // multi_cpl set when more completions follow for this tag
    typedef struct packed {
        logic [LEN_W-1:0]   len;
        logic [TAG_W-1:0]   tag;
        logic [LADDR_W-1:0] low_addr;
        logic [BCNT_W-1:0]  byte_cnt;
        logic               multi_cpl;
    } cpld_hdr_t;

endpackage

`default_nettype wire

// ==== design/rx_stream_pkg.sv ====
// stream beat widths, halt vector width, stream and write beat structs, dword byte swap
`default_nettype none

package rx_stream_pkg;

    localparam int DATA_W    = 128;
    localparam int KEEP_W    = 4;
    localparam int USER_W    = 8;
    localparam int RX_HALT_W = 3;

    // one beat as it comes from the PCIe core
    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        logic              last;
        logic [USER_W-1:0] user;
    } rx_beat_t;

    // payload beat towards the write side, keep is per dword
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] dw_vld;
    } wr_beat_t;

    // little to big endian, bytes reversed inside each dword
    function automatic logic [DATA_W-1:0] dw_byte_swap(input logic [DATA_W-1:0] din);
        logic [DATA_W-1:0] dout;
        for (int dw = 0; dw < KEEP_W; dw++)
        begin
            for (int b = 0; b < 4; b++)
            begin
                dout[dw*32 + b*8 +: 8] = din[dw*32 + (3-b)*8 +: 8];
            end
        end
        return dout;
    endfunction

endpackage

`default_nettype wire

// ==== design/tlp_rx_decode.sv ====
// receive pipeline, idle/header/data FSM, header classification and field extraction
`default_nettype none
`timescale 1ns/1ps

module tlp_rx_decode
(
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire rx_stream_pkg::rx_beat_t  i_beat,
    output logic                          o_trdy,
    output pcie_tlp_pkg::mrd_hdr_t        o_mrd_hdr,
    output logic                          o_mrd_seen,
    output logic                          o_cpld_last_seen,
    output pcie_tlp_pkg::mwr_hdr_t        o_mwr_hdr,
    output logic                          o_mwr_hdr_stb,
    output pcie_tlp_pkg::cpld_hdr_t       o_cpld_hdr,
    output logic                          o_cpld_hdr_stb,
    output rx_stream_pkg::wr_beat_t       o_wr_beat,
    output logic                          o_mwr_beat_stb,
    output logic                          o_cpld_beat_stb
);

    // state describes the beat sitting in stage 2
    typedef enum logic [1:0] {ST_IDLE, ST_HEAD, ST_DATA} rx_state_e;

    rx_stream_pkg::rx_beat_t         beat_s1;
    rx_stream_pkg::rx_beat_t         beat_s2;
    rx_state_e                       state;
    rx_state_e                       next_state;
    pcie_tlp_pkg::tlp_kind_e         hdr_kind;
    pcie_tlp_pkg::tlp_kind_e         pay_kind;
    logic [7:0]                      fmt_type;
    logic [pcie_tlp_pkg::ADDR_W-1:0] hdr_addr;
    logic                            tlp_open;
    logic                            hdr_vld;
    logic                            pay_vld;

    //////////////////////////////////////////////////
    // input register stages, no back-pressure
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            beat_s1 <= '0;
            beat_s2 <= '0;
        end
        else
        begin
            beat_s1 <= i_beat;
            beat_s2 <= beat_s1;
        end
    end

    assign o_trdy = 1'b1;

    //////////////////////////////////////////////////
    // receive FSM
    //////////////////////////////////////////////////
    // payload still expected once the stage 2 beat has moved on
    always_comb
    begin
        case (state)
            ST_HEAD: tlp_open = beat_s2.data[30] && !beat_s2.last;
            ST_DATA: tlp_open = !(beat_s2.valid && beat_s2.last);
            default: tlp_open = 1'b0;
        endcase
    end

    always_comb
    begin
        if (tlp_open)
            next_state = ST_DATA;
        else if (beat_s1.valid)
            next_state = ST_HEAD;
        else
            next_state = ST_IDLE;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= ST_IDLE;
        else
            state <= next_state;
    end

    assign hdr_vld = (state == ST_HEAD) && beat_s2.valid;
    assign pay_vld = (state == ST_DATA) && beat_s2.valid;

    //////////////////////////////////////////////////
    // header classification
    //////////////////////////////////////////////////
    assign fmt_type = beat_s2.data[31:24];

    always_comb
    begin
        case (fmt_type)
            pcie_tlp_pkg::FMT_TYPE_MRD32,
            pcie_tlp_pkg::FMT_TYPE_MRD64,
            pcie_tlp_pkg::FMT_TYPE_MRDLK32,
            pcie_tlp_pkg::FMT_TYPE_MRDLK64: hdr_kind = pcie_tlp_pkg::TLP_MRD;
            pcie_tlp_pkg::FMT_TYPE_MWR32,
            pcie_tlp_pkg::FMT_TYPE_MWR64:   hdr_kind = pcie_tlp_pkg::TLP_MWR;
            pcie_tlp_pkg::FMT_TYPE_CPLD,
            pcie_tlp_pkg::FMT_TYPE_CPLDLK:  hdr_kind = pcie_tlp_pkg::TLP_CPLD;
            default:                        hdr_kind = pcie_tlp_pkg::TLP_NONE;
        endcase
    end

    // fmt bit 0 marks a 4DW header with a 64-bit address
    assign hdr_addr = fmt_type[5] ? {beat_s2.data[95:64], beat_s2.data[127:98], 2'b00}
                                  : {32'b0, beat_s2.data[95:66], 2'b00};

    // kind of the open TLP, steers its payload beats
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            pay_kind <= pcie_tlp_pkg::TLP_NONE;
        else if (hdr_vld)
            pay_kind <= hdr_kind;
    end

    //////////////////////////////////////////////////
    // field extraction
    //////////////////////////////////////////////////
    assign o_mrd_seen       = hdr_vld && (hdr_kind == pcie_tlp_pkg::TLP_MRD);
    assign o_mwr_hdr_stb    = hdr_vld && (hdr_kind == pcie_tlp_pkg::TLP_MWR);
    assign o_cpld_hdr_stb   = hdr_vld && (hdr_kind == pcie_tlp_pkg::TLP_CPLD);
    // user[3] flags the final completion for a tag
    assign o_cpld_last_seen = o_cpld_hdr_stb && beat_s2.user[3];

    // read request fields go straight to the completion side
    always_ff @(posedge clk)
    begin
        if (o_mrd_seen)
        begin
            o_mrd_hdr.tc     <= beat_s2.data[22:20];
            o_mrd_hdr.attr   <= {beat_s2.data[18], beat_s2.data[13:12]};
            o_mrd_hdr.len    <= beat_s2.data[9:0];
            o_mrd_hdr.req_id <= beat_s2.data[63:48];
            o_mrd_hdr.tag    <= beat_s2.data[47:40];
            o_mrd_hdr.addr   <= hdr_addr;
        end
    end

    always_comb
    begin
        o_mwr_hdr.len  = beat_s2.data[9:0];
        o_mwr_hdr.dwbe = beat_s2.data[39:32];
        o_mwr_hdr.addr = hdr_addr;
        // first payload beat is one stage behind the header
        o_mwr_hdr.bar_hit = beat_s1.user[5:4];

        o_cpld_hdr.len       = beat_s2.data[9:0];
        o_cpld_hdr.tag       = beat_s2.data[79:72];
        o_cpld_hdr.low_addr  = beat_s2.data[70:64];
        o_cpld_hdr.byte_cnt  = beat_s2.data[43:32];
        o_cpld_hdr.multi_cpl = !beat_s2.user[3];
    end

    // shared payload, headers are never swapped
    assign o_wr_beat.data   = rx_stream_pkg::dw_byte_swap(beat_s2.data);
    assign o_wr_beat.dw_vld = beat_s2.keep;

    assign o_mwr_beat_stb  = pay_vld && (pay_kind == pcie_tlp_pkg::TLP_MWR);
    assign o_cpld_beat_stb = pay_vld && (pay_kind == pcie_tlp_pkg::TLP_CPLD);

    a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        state inside {ST_IDLE, ST_HEAD, ST_DATA});

    // the beat after a last beat is always a header
    a_beat_in_data: assert property (@(posedge clk) disable iff (!rst_n)
        (o_mwr_beat_stb || o_cpld_beat_stb) |-> !$past(beat_s2.valid && beat_s2.last));

endmodule

`default_nettype wire

// ==== design/tlp_wr_channel.sv ====
// write channel, holds a decoded header and registers payload beats with a start strobe
`default_nettype none
`timescale 1ns/1ps

module tlp_wr_channel
#(
    parameter type hdr_t = pcie_tlp_pkg::mwr_hdr_t
)
(
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire hdr_t                     i_hdr,
    input  wire                           i_hdr_stb,
    input  wire rx_stream_pkg::wr_beat_t  i_beat,
    input  wire                           i_beat_stb,
    output hdr_t                          o_hdr,
    output logic                          o_wr_start,
    output rx_stream_pkg::wr_beat_t       o_wr_beat
);

    //////////////////////////////////////////////////
    // header hold
    //////////////////////////////////////////////////
    // stays valid for the whole TLP and until the next header
    always_ff @(posedge clk)
    begin
        if (i_hdr_stb)
            o_hdr <= i_hdr;
    end

    //////////////////////////////////////////////////
    // payload beats
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            o_wr_start <= 1'b0;
        else
            o_wr_start <= i_beat_stb;
    end

    // data only meaningful while o_wr_start is high
    always_ff @(posedge clk)
    begin
        if (i_beat_stb)
            o_wr_beat <= i_beat;
    end

    // a header beat never carries payload
    a_hdr_beat_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(i_hdr_stb && i_beat_stb));

endmodule

`default_nettype wire

// ==== design/tlp_req_ctrl.sv ====
// completion request hold, completion tag release pulse and receive halt vector
`default_nettype none
`timescale 1ns/1ps

module tlp_req_ctrl
(
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 i_mrd_seen,
    input  wire                                 i_cpld_last_seen,
    input  wire                                 i_cpld_req_rdy,
    input  wire                                 i_cpld_tx_rdy,
    input  wire                                 i_tag_full,
    output logic                                o_cpld_req_vld,
    output logic                                o_cpld_rcv,
    output logic [rx_stream_pkg::RX_HALT_W-1:0] o_rx_halt
);

    // a new read wins over an accept in the same cycle
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            o_cpld_req_vld <= 1'b0;
        else if (i_mrd_seen)
            o_cpld_req_vld <= 1'b1;
        else if (i_cpld_req_rdy)
            o_cpld_req_vld <= 1'b0;
    end

    // tag release on the last completion only
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            o_cpld_rcv <= 1'b0;
        else
            o_cpld_rcv <= i_cpld_last_seen;
    end

    //////////////////////////////////////////////////
    // halt vector: posted, non-posted, completions
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            o_rx_halt <= '0;
        else
            o_rx_halt <= {1'b0, !i_cpld_tx_rdy, i_tag_full};
    end

    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(o_cpld_req_vld) |-> $past(i_cpld_req_rdy));

endmodule

`default_nettype wire

// ==== design/tlp_rcv_top.sv ====
// receive top level, decode with MWr and CplD write channels and request control
`default_nettype none
`timescale 1ns/1ps

module tlp_rcv_top
(
    input  wire                                 clk,
    input  wire                                 rst_n,
    // stream from the PCIe core
    input  wire                                 i_axis_tvld,
    input  wire [rx_stream_pkg::DATA_W-1:0]     i_axis_tdata,
    input  wire [rx_stream_pkg::KEEP_W-1:0]     i_axis_tkeep,
    input  wire                                 i_axis_tlast,
    input  wire [rx_stream_pkg::USER_W-1:0]     i_axis_tuser,
    output logic                                o_axis_trdy,
    // completion side
    input  wire                                 i_cpld_req_rdy,
    input  wire                                 i_cpld_tx_rdy,
    input  wire                                 i_tag_full,
    output pcie_tlp_pkg::mrd_hdr_t              o_mrd_hdr,
    output logic                                o_cpld_req_vld,
    output logic                                o_cpld_rcv,
    output logic [rx_stream_pkg::RX_HALT_W-1:0] o_rx_halt,
    // write side
    output pcie_tlp_pkg::mwr_hdr_t              o_mwr_hdr,
    output logic                                o_mwr_wr_start,
    output rx_stream_pkg::wr_beat_t             o_mwr_beat,
    output pcie_tlp_pkg::cpld_hdr_t             o_cpld_hdr,
    output logic                                o_cpld_wr_start,
    output rx_stream_pkg::wr_beat_t             o_cpld_beat
);

    rx_stream_pkg::rx_beat_t   rx_beat;
    pcie_tlp_pkg::mwr_hdr_t    mwr_hdr;
    pcie_tlp_pkg::cpld_hdr_t   cpld_hdr;
    rx_stream_pkg::wr_beat_t   wr_beat;
    logic                      mwr_hdr_stb;
    logic                      cpld_hdr_stb;
    logic                      mwr_beat_stb;
    logic                      cpld_beat_stb;
    logic                      mrd_seen;
    logic                      cpld_last_seen;

    assign rx_beat.valid = i_axis_tvld;
    assign rx_beat.data  = i_axis_tdata;
    assign rx_beat.keep  = i_axis_tkeep;
    assign rx_beat.last  = i_axis_tlast;
    assign rx_beat.user  = i_axis_tuser;

    tlp_rx_decode decode_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .i_beat           (rx_beat),
        .o_trdy           (o_axis_trdy),
        .o_mrd_hdr        (o_mrd_hdr),
        .o_mrd_seen       (mrd_seen),
        .o_cpld_last_seen (cpld_last_seen),
        .o_mwr_hdr        (mwr_hdr),
        .o_mwr_hdr_stb    (mwr_hdr_stb),
        .o_cpld_hdr       (cpld_hdr),
        .o_cpld_hdr_stb   (cpld_hdr_stb),
        .o_wr_beat        (wr_beat),
        .o_mwr_beat_stb   (mwr_beat_stb),
        .o_cpld_beat_stb  (cpld_beat_stb)
    );

    //////////////////////////////////////////////////
    // write channels
    //////////////////////////////////////////////////
    tlp_wr_channel #(.hdr_t(pcie_tlp_pkg::mwr_hdr_t)) mwr_chan_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_hdr      (mwr_hdr),
        .i_hdr_stb  (mwr_hdr_stb),
        .i_beat     (wr_beat),
        .i_beat_stb (mwr_beat_stb),
        .o_hdr      (o_mwr_hdr),
        .o_wr_start (o_mwr_wr_start),
        .o_wr_beat  (o_mwr_beat)
    );

    tlp_wr_channel #(.hdr_t(pcie_tlp_pkg::cpld_hdr_t)) cpld_chan_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_hdr      (cpld_hdr),
        .i_hdr_stb  (cpld_hdr_stb),
        .i_beat     (wr_beat),
        .i_beat_stb (cpld_beat_stb),
        .o_hdr      (o_cpld_hdr),
        .o_wr_start (o_cpld_wr_start),
        .o_wr_beat  (o_cpld_beat)
    );

    tlp_req_ctrl req_ctrl_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .i_mrd_seen       (mrd_seen),
        .i_cpld_last_seen (cpld_last_seen),
        .i_cpld_req_rdy   (i_cpld_req_rdy),
        .i_cpld_tx_rdy    (i_cpld_tx_rdy),
        .i_tag_full       (i_tag_full),
        .o_cpld_req_vld   (o_cpld_req_vld),
        .o_cpld_rcv       (o_cpld_rcv),
        .o_rx_halt        (o_rx_halt)
    );

endmodule

`default_nettype wire

// ==== dv/tlp_rcv_tests.svh ====
// header builders, expected-value checks and directed TLP tests

function automatic logic [31:0] make_dw0(input logic [7:0] ft, input logic [2:0] tc,
                                         input logic [2:0] attr, input logic [9:0] len);
    return {ft, 1'b0, tc, 1'b0, attr[2], 4'b0, attr[1:0], 2'b0, len};
endfunction

// 64-bit address goes upper half in dword2, lower half in dword3
function automatic logic [127:0] make_mrd(input logic [7:0] ft, input logic [63:0] addr,
                                          input logic [2:0] tc, input logic [2:0] attr,
                                          input logic [9:0] len, input logic [15:0] id,
                                          input logic [7:0] tag);
    logic [31:0] dw1;
    dw1 = {id, tag, 8'hff};
    if (ft[5])
        return {addr[31:0], addr[63:32], dw1, make_dw0(ft, tc, attr, len)};
    return {32'h0, addr[31:0], dw1, make_dw0(ft, tc, attr, len)};
endfunction

// header beat then payload beats, last on the final one
task automatic send_write(input logic [127:0] hdr, input logic [7:0] hdr_user,
                          input int nbeats, input logic [1:0] bar, input bit to_cpld);
    logic [127:0] d;
    logic [3:0]   k;
    drive_beat(hdr, 4'hf, 1'b0, hdr_user);
    for (int i = 0; i < nbeats; i++)
    begin
        d = {rand_word(), rand_word(), rand_word(), rand_word()};
        k = (i == nbeats - 1) ? 4'b0011 : ((i == 0) ? 4'hf : 4'b0111);
        drive_beat(d, k, i == nbeats - 1, {2'b0, bar, 4'h0});
        if (to_cpld)
            cpld_exp.push_back({swap_dwords(d), k});
        else
            mwr_exp.push_back({swap_dwords(d), k});
    end
endtask

task automatic check_writes(input bit to_cpld);
    logic [131:0] e;
    logic [131:0] g;
    int           n;
    n = to_cpld ? cpld_exp.size() : mwr_exp.size();
    while ((to_cpld ? cpld_got.size() : mwr_got.size()) < n)
        @(negedge clk);
    // no extra strobes once the pipe has drained
    repeat (4) @(negedge clk);
    check_val("write beat count", 128'(n), 128'(to_cpld ? cpld_got.size() : mwr_got.size()));
    for (int i = 0; i < n; i++)
    begin
        if (to_cpld)
        begin
            e = cpld_exp.pop_front();
            g = cpld_got.pop_front();
        end
        else
        begin
            e = mwr_exp.pop_front();
            g = mwr_got.pop_front();
        end
        check_val("write data", e[131:4], g[131:4]);
        check_val("write keep", 128'(e[3:0]), 128'(g[3:0]));
    end
endtask

task automatic check_mrd(input logic [2:0] tc, input logic [2:0] attr, input logic [9:0] len,
                         input logic [15:0] id, input logic [7:0] tag,
                         input logic [63:0] addr);
    while (!o_cpld_req_vld)
        @(negedge clk);
    check_val("mrd tc", 128'(tc), 128'(o_mrd_hdr.tc));
    check_val("mrd attr", 128'(attr), 128'(o_mrd_hdr.attr));
    check_val("mrd len", 128'(len), 128'(o_mrd_hdr.len));
    check_val("mrd id", 128'(id), 128'(o_mrd_hdr.req_id));
    check_val("mrd tag", 128'(tag), 128'(o_mrd_hdr.tag));
    check_val("mrd addr", 128'(addr), 128'(o_mrd_hdr.addr));
    repeat (5) @(negedge clk);
    check_val("req vld held", 128'(1'b1), 128'(o_cpld_req_vld));
    @(posedge clk);
    #2;
    i_cpld_req_rdy = 1'b1;
    @(posedge clk);
    #2;
    i_cpld_req_rdy = 1'b0;
    @(negedge clk);
    check_val("req vld released", 128'(0), 128'(o_cpld_req_vld));
endtask

task automatic test_mrd();
    drive_beat(make_mrd(pcie_tlp_pkg::FMT_TYPE_MRD32, 64'h0000_0000_abcd_1237, 3'd5, 3'b101,
                        10'd16, 16'h0108, 8'h3c), 4'h7, 1'b1, 8'h00);
    drive_idle();
    check_mrd(3'd5, 3'b101, 10'd16, 16'h0108, 8'h3c, 64'h0000_0000_abcd_1234);
    drive_beat(make_mrd(pcie_tlp_pkg::FMT_TYPE_MRDLK64, 64'h0000_0012_8765_4322, 3'd2,
                        3'b010, 10'd1, 16'h0200, 8'h7f), 4'hf, 1'b1, 8'h00);
    drive_idle();
    check_mrd(3'd2, 3'b010, 10'd1, 16'h0200, 8'h7f, 64'h0000_0012_8765_4320);
endtask

task automatic test_mwr32();
    send_write({32'h0, 32'h1234_5678, 32'h0100_00f0,
                make_dw0(pcie_tlp_pkg::FMT_TYPE_MWR32, 3'd0, 3'd0, 10'd11)}, 8'h00, 3,
               2'b10, 1'b0);
    drive_idle();
    check_writes(1'b0);
    check_val("mwr addr", 128'(64'h1234_5678), 128'(o_mwr_hdr.addr));
    check_val("mwr be", 128'(8'hf0), 128'(o_mwr_hdr.dwbe));
    check_val("mwr len", 128'(10'd11), 128'(o_mwr_hdr.len));
    check_val("mwr bar", 128'(2'b10), 128'(o_mwr_hdr.bar_hit));
endtask

task automatic test_mwr64();
    send_write({32'hdead_beec, 32'h0000_0001, 32'h0100_000f,
                make_dw0(pcie_tlp_pkg::FMT_TYPE_MWR64, 3'd0, 3'd0, 10'd3)}, 8'h00, 1,
               2'b01, 1'b0);
    drive_idle();
    check_writes(1'b0);
    check_val("mwr64 addr", 128'(64'h0000_0001_dead_beec), 128'(o_mwr_hdr.addr));
    check_val("mwr64 bar", 128'(2'b01), 128'(o_mwr_hdr.bar_hit));
endtask

// completion: byte count in dword1, tag and lower address in dword2
task automatic test_cpld(input bit last_cpl);
    int rcv_before;
    rcv_before = cpld_rcv_cnt;
    send_write({32'h0, 32'h0108_a544, 32'h0100_0ff0,
                make_dw0(pcie_tlp_pkg::FMT_TYPE_CPLD, 3'd0, 3'd0, 10'd6)},
               {4'h0, last_cpl, 3'b0}, 2, 2'b00, 1'b1);
    drive_idle();
    check_writes(1'b1);
    check_val("cpld tag", 128'(8'ha5), 128'(o_cpld_hdr.tag));
    check_val("cpld low addr", 128'(7'h44), 128'(o_cpld_hdr.low_addr));
    check_val("cpld byte cnt", 128'(12'hff0), 128'(o_cpld_hdr.byte_cnt));
    check_val("cpld len", 128'(10'd6), 128'(o_cpld_hdr.len));
    check_val("cpld multi", 128'(!last_cpl), 128'(o_cpld_hdr.multi_cpl));
    check_val("cpld rcv pulses", 128'(last_cpl ? 1 : 0), 128'(cpld_rcv_cnt - rcv_before));
endtask

task automatic test_halt_b2b();
    @(posedge clk);
    #2;
    i_tag_full    = 1'b1;
    i_cpld_tx_rdy = 1'b0;
    // not registered until the next edge
    @(negedge clk);
    check_val("halt before edge", 128'(0), 128'(o_rx_halt));
    @(posedge clk);
    #2;
    i_tag_full = 1'b0;
    @(negedge clk);
    check_val("halt both", 128'(3'b011), 128'(o_rx_halt));
    @(posedge clk);
    #2;
    i_cpld_tx_rdy = 1'b1;
    @(negedge clk);
    check_val("halt tx", 128'(3'b010), 128'(o_rx_halt));
    @(posedge clk);
    @(negedge clk);
    check_val("halt clear", 128'(0), 128'(o_rx_halt));
    // MWr, CplD and MRd with no idle beat between them
    send_write({32'h0, 32'h0000_4000, 32'h0100_00ff,
                make_dw0(pcie_tlp_pkg::FMT_TYPE_MWR32, 3'd0, 3'd0, 10'd8)}, 8'h00, 2,
               2'b11, 1'b0);
    send_write({32'h0, 32'h0108_1100, 32'h0100_0004,
                make_dw0(pcie_tlp_pkg::FMT_TYPE_CPLDLK, 3'd0, 3'd0, 10'd1)}, 8'h08, 1,
               2'b00, 1'b1);
    drive_beat(make_mrd(pcie_tlp_pkg::FMT_TYPE_MRD32, 64'h0000_0000_0000_8000, 3'd1, 3'd0,
                        10'd2, 16'h0300, 8'h21), 4'h7, 1'b1, 8'h00);
    drive_idle();
    check_mrd(3'd1, 3'd0, 10'd2, 16'h0300, 8'h21, 64'h0000_0000_0000_8000);
    check_writes(1'b0);
    check_writes(1'b1);
    check_val("b2b mwr addr", 128'(64'h4000), 128'(o_mwr_hdr.addr));
    check_val("b2b mwr bar", 128'(2'b11), 128'(o_mwr_hdr.bar_hit));
    check_val("b2b cpld tag", 128'(8'h11), 128'(o_cpld_hdr.tag));
    check_val("b2b cpld multi", 128'(0), 128'(o_cpld_hdr.multi_cpl));
endtask

// ==== dv/tlp_rcv_tb.sv ====
// testbench top with clock, reset, DUT, LFSR, check task, write monitor and timeout
`default_nettype none
`timescale 1ns/1ps

module tlp_rcv_tb;

    localparam int MAX_CYCLES = 2000;

    logic                        clk;
    logic                        rst_n;
    logic                        i_axis_tvld;
    logic [127:0]                i_axis_tdata;
    logic [3:0]                  i_axis_tkeep;
    logic                        i_axis_tlast;
    logic [7:0]                  i_axis_tuser;
    logic                        o_axis_trdy;
    logic                        i_cpld_req_rdy;
    logic                        i_cpld_tx_rdy;
    logic                        i_tag_full;
    pcie_tlp_pkg::mrd_hdr_t      o_mrd_hdr;
    logic                        o_cpld_req_vld;
    logic                        o_cpld_rcv;
    logic [2:0]                  o_rx_halt;
    pcie_tlp_pkg::mwr_hdr_t      o_mwr_hdr;
    logic                        o_mwr_wr_start;
    rx_stream_pkg::wr_beat_t     o_mwr_beat;
    pcie_tlp_pkg::cpld_hdr_t     o_cpld_hdr;
    logic                        o_cpld_wr_start;
    rx_stream_pkg::wr_beat_t     o_cpld_beat;

    logic [31:0]  lfsr_state;
    int           cycles;
    int           cpld_rcv_cnt;
    // {data, dword keep} per write beat
    logic [131:0] mwr_exp[$];
    logic [131:0] mwr_got[$];
    logic [131:0] cpld_exp[$];
    logic [131:0] cpld_got[$];

    tlp_rcv_top tlp_rcv_top_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    task automatic check_val(input string what, input logic [127:0] exp,
                             input logic [127:0] act);
        if (exp !== act)
        begin
            $display("[ERROR] %0t ns: %s expected %h got %h", $time, what, exp, act);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch");
        end
    endtask

    // galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        logic        b;
        w = '0;
        for (int i = 0; i < 32; i++)
        begin
            b = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (b)
                lfsr_state = lfsr_state ^ 32'h8020_0003;
            w = {w[30:0], b};
        end
        return w;
    endfunction

    // bytes reversed inside each dword
    function automatic logic [127:0] swap_dwords(input logic [127:0] d);
        logic [127:0] r;
        for (int i = 0; i < 4; i++)
        begin
            r[i*32 +: 32] = {d[i*32 +: 8], d[i*32+8 +: 8], d[i*32+16 +: 8], d[i*32+24 +: 8]};
        end
        return r;
    endfunction

    task automatic drive_beat(input logic [127:0] d, input logic [3:0] k,
                              input logic l, input logic [7:0] u);
        @(posedge clk);
        #2;
        i_axis_tvld  = 1'b1;
        i_axis_tdata = d;
        i_axis_tkeep = k;
        i_axis_tlast = l;
        i_axis_tuser = u;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        #2;
        i_axis_tvld  = 1'b0;
        i_axis_tlast = 1'b0;
    endtask

    // write outputs sampled away from the clock edge
    always @(negedge clk)
    begin
        if (o_mwr_wr_start)
            mwr_got.push_back({o_mwr_beat.data, o_mwr_beat.dw_vld});
        if (o_cpld_wr_start)
            cpld_got.push_back({o_cpld_beat.data, o_cpld_beat.dw_vld});
        if (o_cpld_rcv)
            cpld_rcv_cnt++;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > MAX_CYCLES)
        begin
            $display("timeout after %0d cycles, DUT did not respond", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    `include "tlp_rcv_tests.svh"

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////
    initial
    begin
        lfsr_state     = 32'h8f55_8c90;
        cycles         = 0;
        cpld_rcv_cnt   = 0;
        rst_n          = 1'b0;
        i_axis_tvld    = 1'b0;
        i_axis_tdata   = '0;
        i_axis_tkeep   = '0;
        i_axis_tlast   = 1'b0;
        i_axis_tuser   = '0;
        i_cpld_req_rdy = 1'b0;
        i_cpld_tx_rdy  = 1'b1;
        i_tag_full     = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_val("trdy", 128'(1'b1), 128'(o_axis_trdy));
        check_val("req vld after reset", 128'(0), 128'(o_cpld_req_vld));
        check_val("halt after reset", 128'(0), 128'(o_rx_halt));
        test_mrd();
        test_mwr32();
        test_mwr64();
        test_cpld(1'b1);
        test_cpld(1'b0);
        test_halt_b2b();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
design/pcie_tlp_pkg.sv
design/rx_stream_pkg.sv
design/tlp_rx_decode.sv
design/tlp_wr_channel.sv
design/tlp_req_ctrl.sv
design/tlp_rcv_top.sv
+incdir+dv
dv/tlp_rcv_tb.sv

// ==== Makefile ====
TOP := tlp_rcv_tb

.PHONY: all lint clean

all:
	verilator --binary --assert --timing -f sim.f --top-module $(TOP) -o V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; status=$$?; echo "$$out"; \
	test $$status -eq 0 && echo "$$out" | grep -q "TEST RESULT: PASS"

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir
